//--- source/sys_pkg.sv
package sys_pkg;

  // datapath and pc width.
  localparam int xlen = 32;

  // csr address width.
  localparam int csr_addr_w = 12;

  // major opcode of the SYSTEM group.
  localparam logic [6:0] opcode_system = 7'b1110011;

  // funct12 immediates that tell the funct3 0 instructions apart.
  localparam logic [11:0] funct12_ecall = 12'h000;
  localparam logic [11:0] funct12_mret = 12'h302;

  // machine-mode CSR addresses.
  localparam logic [csr_addr_w-1:0] csr_mstatus = 12'h300;
  localparam logic [csr_addr_w-1:0] csr_mtvec = 12'h305;
  localparam logic [csr_addr_w-1:0] csr_mepc = 12'h341;
  localparam logic [csr_addr_w-1:0] csr_mcause = 12'h342;
  localparam logic [csr_addr_w-1:0] csr_mvendorid = 12'hF11;
  localparam logic [csr_addr_w-1:0] csr_marchid = 12'hF12;

  // mstatus fields.
  localparam int mstatus_mie_idx = 3;
  localparam int mstatus_mpie_idx = 7;

  // read-only identification values.
  localparam logic [xlen-1:0] mvendorid_val = 32'h7973_7978;
  localparam logic [xlen-1:0] marchid_val = 32'h015f_de77;

  // environment call from M-mode.
  localparam logic [xlen-1:0] mcause_ecall = 32'd11;

  // operations of the system unit.
  typedef enum logic [2:0] {
    op_csrrw,
    op_csrrs,
    op_csrrc,
    op_ecall,
    op_mret,
    op_invalid
  } sys_op_e;

endpackage

//--- source/sys_decode.sv
`timescale 1ns/10ps

module sys_decode (
  input  logic [31:0]                   instr,
  output sys_pkg::sys_op_e              op,
  output logic [sys_pkg::csr_addr_w-1:0] csr_addr,
  output logic                          use_imm,
  output logic [4:0]                    zimm,
  output logic                          rs1_nonzero,
  output logic                          rd_nonzero
);
  import sys_pkg::*;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [11:0] funct12;
  logic        is_system;

  assign opcode  = instr[6:0];
  assign funct3  = instr[14:12];
  assign funct12 = instr[31:20];

  assign is_system = (opcode == opcode_system);

  // the csr address shares its bits with funct12.
  assign csr_addr = instr[31:20];

  // rs1 field doubles as the 5-bit immediate.
  assign zimm        = instr[19:15];
  assign use_imm     = funct3[2];
  assign rs1_nonzero = |instr[19:15];
  assign rd_nonzero  = |instr[11:7];

  always_comb begin
    op = op_invalid;
    if (is_system) begin
      case (funct3)
        3'd0: begin
          if (funct12 == funct12_ecall) begin
            op = op_ecall;
          end else if (funct12 == funct12_mret) begin
            op = op_mret;
          end
        end
        3'd1, 3'd5: op = op_csrrw;
        3'd2, 3'd6: op = op_csrrs;
        3'd3, 3'd7: op = op_csrrc;
        default:    op = op_invalid; // funct3 4 is reserved.
      endcase
    end
  end

endmodule

//--- source/csr_update.sv
`timescale 1ns/10ps

module csr_update (
  input  sys_pkg::sys_op_e          op,
  input  logic                      use_imm,
  input  logic [4:0]                zimm,
  input  logic                      rs1_nonzero,
  input  logic [sys_pkg::xlen-1:0]  rs1_data,
  input  logic [sys_pkg::xlen-1:0]  old_value,
  output logic [sys_pkg::xlen-1:0]  csr_wdata,
  output logic                      write_attempt
);
  import sys_pkg::*;

  logic [xlen-1:0] operand;

  assign operand = use_imm ? {{(xlen-5){1'b0}}, zimm} : rs1_data;

  always_comb begin
    csr_wdata     = old_value;
    write_attempt = 1'b0;
    case (op)
      op_csrrw: begin
        csr_wdata     = operand;
        write_attempt = 1'b1;
      end
      op_csrrs: begin
        csr_wdata     = old_value | operand;
        write_attempt = rs1_nonzero; // also zero for zimm 0.
      end
      op_csrrc: begin
        csr_wdata     = old_value & ~operand;
        write_attempt = rs1_nonzero;
      end
      default: begin
        csr_wdata     = old_value;
        write_attempt = 1'b0;
      end
    endcase
  end

endmodule

//--- source/csr_file.sv
`timescale 1ns/10ps

module csr_file (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [sys_pkg::csr_addr_w-1:0] csr_addr,
  input  logic [sys_pkg::xlen-1:0]      csr_wdata,
  input  logic                          csr_we,
  input  logic                          ecall_take,
  input  logic                          mret_take,
  input  logic [sys_pkg::xlen-1:0]      epc,
  output logic [sys_pkg::xlen-1:0]      csr_rdata,
  output logic                          csr_hit,
  output logic                          csr_ro,
  output logic [sys_pkg::xlen-1:0]      mepc,
  output logic [sys_pkg::xlen-1:0]      mtvec
);
  import sys_pkg::*;

  logic [xlen-1:0] mstatus_q;
  logic [xlen-1:0] mcause_q;
  logic [xlen-1:0] mepc_q;
  logic [xlen-1:0] mtvec_q;

  logic sel_mstatus;
  logic sel_mcause;
  logic sel_mepc;
  logic sel_mtvec;
  logic sel_mvendorid;
  logic sel_marchid;

  // one-hot address decode.
  assign sel_mstatus   = (csr_addr == csr_mstatus);
  assign sel_mcause    = (csr_addr == csr_mcause);
  assign sel_mepc      = (csr_addr == csr_mepc);
  assign sel_mtvec     = (csr_addr == csr_mtvec);
  assign sel_mvendorid = (csr_addr == csr_mvendorid);
  assign sel_marchid   = (csr_addr == csr_marchid);

  assign csr_ro  = sel_mvendorid | sel_marchid;
  assign csr_hit = sel_mstatus | sel_mcause | sel_mepc | sel_mtvec | csr_ro;

  // and-or read mux, zero on a miss.
  assign csr_rdata = ({xlen{sel_mstatus}}   & mstatus_q)
                   | ({xlen{sel_mcause}}    & mcause_q)
                   | ({xlen{sel_mepc}}      & mepc_q)
                   | ({xlen{sel_mtvec}}     & mtvec_q)
                   | ({xlen{sel_mvendorid}} & mvendorid_val)
                   | ({xlen{sel_marchid}}   & marchid_val);

  assign mepc  = mepc_q;
  assign mtvec = mtvec_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mcause_q  <= '0;
      mepc_q    <= '0;
      mtvec_q   <= '0;
    end else if (ecall_take) begin
      mepc_q   <= epc;
      mcause_q <= mcause_ecall;
      mstatus_q[mstatus_mpie_idx] <= mstatus_q[mstatus_mie_idx]; // stack the enable.
      mstatus_q[mstatus_mie_idx]  <= 1'b0;
    end else if (mret_take) begin
      mstatus_q[mstatus_mie_idx]  <= mstatus_q[mstatus_mpie_idx];
      mstatus_q[mstatus_mpie_idx] <= 1'b1;
    end else if (csr_we) begin
      if (sel_mstatus) begin
        mstatus_q <= csr_wdata;
      end
      if (sel_mcause) begin
        mcause_q <= csr_wdata;
      end
      if (sel_mepc) begin
        mepc_q <= csr_wdata;
      end
      if (sel_mtvec) begin
        mtvec_q <= csr_wdata;
      end
    end
  end

endmodule

//--- source/sys_commit.sv
`timescale 1ns/10ps

module sys_commit (
  input  logic                      valid,
  input  sys_pkg::sys_op_e          op,
  input  logic                      write_attempt,
  input  logic                      rd_nonzero,
  input  logic                      csr_hit,
  input  logic                      csr_ro,
  input  logic [sys_pkg::xlen-1:0]  pc,
  input  logic [sys_pkg::xlen-1:0]  csr_rdata,
  input  logic [sys_pkg::xlen-1:0]  mepc,
  input  logic [sys_pkg::xlen-1:0]  mtvec,
  output logic                      rd_wen,
  output logic [sys_pkg::xlen-1:0]  rd_data,
  output logic                      redirect,
  output logic [sys_pkg::xlen-1:0]  next_pc,
  output logic                      illegal,
  output logic                      csr_we,
  output logic                      ecall_take,
  output logic                      mret_take
);
  import sys_pkg::*;

  logic is_csr;
  logic bad;
  logic legal;

  assign is_csr = (op == op_csrrw) | (op == op_csrrs) | (op == op_csrrc);

  // read-only csrs may still be read by set or clear with a zero mask.
  assign bad = (op == op_invalid)
             | (is_csr & ~csr_hit)
             | (is_csr & write_attempt & csr_ro);

  assign legal   = valid & ~bad;
  assign illegal = valid & bad;

  assign rd_wen     = legal & is_csr & rd_nonzero;
  assign rd_data    = csr_rdata; // old value before the write.
  assign csr_we     = legal & is_csr & write_attempt;
  assign ecall_take = legal & (op == op_ecall);
  assign mret_take  = legal & (op == op_mret);

  assign redirect = ecall_take | mret_take;
  assign next_pc  = ecall_take ? mtvec : mret_take ? mepc : pc + xlen'(4);

endmodule

//--- source/exu_sys.sv
`timescale 1ns/10ps

module exu_sys (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      valid,
  input  logic [31:0]               instr,
  input  logic [sys_pkg::xlen-1:0]  pc,
  input  logic [sys_pkg::xlen-1:0]  rs1_data,
  output logic                      rd_wen,
  output logic [sys_pkg::xlen-1:0]  rd_data,
  output logic                      redirect,
  output logic [sys_pkg::xlen-1:0]  next_pc,
  output logic                      illegal
);
  import sys_pkg::*;

  sys_op_e               op;
  logic [csr_addr_w-1:0] csr_addr;
  logic                  use_imm;
  logic [4:0]            zimm;
  logic                  rs1_nonzero;
  logic                  rd_nonzero;
  logic [xlen-1:0]       csr_wdata;
  logic                  write_attempt;
  logic [xlen-1:0]       csr_rdata;
  logic                  csr_hit;
  logic                  csr_ro;
  logic [xlen-1:0]       mepc;
  logic [xlen-1:0]       mtvec;
  logic                  csr_we;
  logic                  ecall_take;
  logic                  mret_take;

  sys_decode u_decode (
    .instr       (instr),
    .op          (op),
    .csr_addr    (csr_addr),
    .use_imm     (use_imm),
    .zimm        (zimm),
    .rs1_nonzero (rs1_nonzero),
    .rd_nonzero  (rd_nonzero)
  );

  csr_update u_update (
    .op            (op),
    .use_imm       (use_imm),
    .zimm          (zimm),
    .rs1_nonzero   (rs1_nonzero),
    .rs1_data      (rs1_data),
    .old_value     (csr_rdata),
    .csr_wdata     (csr_wdata),
    .write_attempt (write_attempt)
  );

  csr_file u_csr (
    .clk        (clk),
    .rst        (rst),
    .csr_addr   (csr_addr),
    .csr_wdata  (csr_wdata),
    .csr_we     (csr_we),
    .ecall_take (ecall_take),
    .mret_take  (mret_take),
    .epc        (pc), // ecall saves its own pc.
    .csr_rdata  (csr_rdata),
    .csr_hit    (csr_hit),
    .csr_ro     (csr_ro),
    .mepc       (mepc),
    .mtvec      (mtvec)
  );

  sys_commit u_commit (
    .valid         (valid),
    .op            (op),
    .write_attempt (write_attempt),
    .rd_nonzero    (rd_nonzero),
    .csr_hit       (csr_hit),
    .csr_ro        (csr_ro),
    .pc            (pc),
    .csr_rdata     (csr_rdata),
    .mepc          (mepc),
    .mtvec         (mtvec),
    .rd_wen        (rd_wen),
    .rd_data       (rd_data),
    .redirect      (redirect),
    .next_pc       (next_pc),
    .illegal       (illegal),
    .csr_we        (csr_we),
    .ecall_take    (ecall_take),
    .mret_take     (mret_take)
  );

endmodule

//--- tests/exu_sys_tb.sv
`timescale 1ns/10ps

module exu_sys_tb;
  import sys_pkg::*;

  typedef struct packed {
    logic        v;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1;
    logic        wen;
    logic [31:0] rd;
    logic        redir;
    logic [31:0] npc;
    logic        ill;
  } vec_t;

  logic        clk;
  logic        rst;
  logic        valid;
  logic [31:0] instr;
  logic [31:0] pc;
  logic [31:0] rs1_data;
  logic        rd_wen;
  logic [31:0] rd_data;
  logic        redirect;
  logic [31:0] next_pc;
  logic        illegal;

  vec_t        vecs [0:39];
  int          n_vec;
  int          errors;
  int          checks;
  int          wait_cnt;
  logic [31:0] rnd;
  logic [31:0] wval;
  logic [31:0] rpc;
  logic [31:0] sh_mtvec;
  logic [31:0] sh_mepc;
  logic [11:0] addr;
  logic        is_write;

  exu_sys uut (
    .clk      (clk),
    .rst      (rst),
    .valid    (valid),
    .instr    (instr),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rd_wen   (rd_wen),
    .rd_data  (rd_data),
    .redirect (redirect),
    .next_pc  (next_pc),
    .illegal  (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

  // SYSTEM opcode with csr in the funct12 field.
  function automatic logic [31:0] csr_instr(input logic [2:0] f3, input logic [11:0] csr,
                                            input logic [4:0] rs1, input logic [4:0] rd);
    return {csr, rs1, f3, rd, 7'b1110011};
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic add_vec(input logic v, input logic [31:0] ins, input logic [31:0] p,
                         input logic [31:0] rs1, input logic wen, input logic [31:0] rd,
                         input logic redir, input logic [31:0] npc, input logic ill);
    vecs[n_vec] = {v, ins, p, rs1, wen, rd, redir, redir ? npc : p + 32'd4, ill};
    n_vec = n_vec + 1;
  endtask

  task automatic drive(input logic v, input logic [31:0] ins, input logic [31:0] p,
                       input logic [31:0] rs1);
    @(negedge clk);
    valid    = v;
    instr    = ins;
    pc       = p;
    rs1_data = rs1;
    #15; // settle, well before the next rising edge.
  endtask

  task automatic check_outputs(input string tag, input logic wen, input logic [31:0] rd,
                               input logic redir, input logic [31:0] npc, input logic ill);
    checks = checks + 1;
    if (rd_wen !== wen) begin
      errors = errors + 1;
      $display("Mismatch at %0t: %s rd_wen %0b, expected %0b", $time, tag, rd_wen, wen);
    end
    if (wen && rd_data !== rd) begin
      errors = errors + 1;
      $display("Mismatch at %0t: %s rd_data %h, expected %h", $time, tag, rd_data, rd);
    end
    if (redirect !== redir) begin
      errors = errors + 1;
      $display("Mismatch at %0t: %s redirect %0b, expected %0b", $time, tag, redirect, redir);
    end
    if (next_pc !== npc) begin
      errors = errors + 1;
      $display("Mismatch at %0t: %s next_pc %h, expected %h", $time, tag, next_pc, npc);
    end
    if (illegal !== ill) begin
      errors = errors + 1;
      $display("Mismatch at %0t: %s illegal %0b, expected %0b", $time, tag, illegal, ill);
    end
  endtask

  task automatic apply_table();
    for (int i = 0; i < n_vec; i++) begin
      drive(vecs[i].v, vecs[i].instr, vecs[i].pc, vecs[i].rs1);
      check_outputs($sformatf("row %0d", i), vecs[i].wen, vecs[i].rd, vecs[i].redir,
                    vecs[i].npc, vecs[i].ill);
    end
  endtask

  task automatic run_random();
    rnd      = 32'd93092;
    sh_mtvec = 32'h102; // state left by the table.
    sh_mepc  = 32'h1048;
    for (int i = 0; i < 40; i++) begin
      rnd      = xorshift(rnd);
      addr     = rnd[0] ? csr_mtvec : csr_mepc;
      is_write = (i % 2 == 0);
      rnd      = xorshift(rnd);
      wval     = rnd;
      rpc      = 32'h2000 + i * 4;
      drive(1'b1, is_write ? csr_instr(1, addr, 2, 6) : csr_instr(2, addr, 0, 6), rpc, wval);
      check_outputs($sformatf("random op %0d", i), 1'b1,
                    (addr == csr_mtvec) ? sh_mtvec : sh_mepc, 1'b0, rpc + 32'd4, 1'b0);
      if (is_write) begin
        if (addr == csr_mtvec) begin
          sh_mtvec = wval;
        end else begin
          sh_mepc = wval;
        end
      end
    end
  endtask

  initial begin
    valid    = 1'b0;
    instr    = 32'h0;
    pc       = 32'h0;
    rs1_data = 32'h0;
    n_vec    = 0;
    errors   = 0;
    checks   = 0;
    // v, instr, pc, rs1_data, rd_wen, rd_data, redirect, next_pc, illegal.
    add_vec(1, csr_instr(2, csr_mstatus, 0, 5), 32'h1000, 0, 1, 0, 0, 0, 0);
    add_vec(1, csr_instr(2, csr_mcause, 0, 5), 32'h1004, 0, 1, 0, 0, 0, 0);
    add_vec(1, csr_instr(2, csr_mepc, 0, 5), 32'h1008, 0, 1, 0, 0, 0, 0);
    add_vec(1, csr_instr(2, csr_mtvec, 0, 5), 32'h100c, 0, 1, 0, 0, 0, 0);
    add_vec(1, csr_instr(2, csr_mvendorid, 0, 5), 32'h1010, 0, 1, mvendorid_val, 0, 0, 0);
    add_vec(1, csr_instr(2, csr_marchid, 0, 5), 32'h1014, 0, 1, marchid_val, 0, 0, 0);
    add_vec(1, csr_instr(1, csr_mtvec, 1, 5), 32'h1018, 32'h8000_0100, 1, 0, 0, 0, 0);
    add_vec(1, csr_instr(2, csr_mtvec, 1, 5), 32'h101c, 32'h3, 1, 32'h8000_0100, 0, 0, 0);
    add_vec(1, csr_instr(3, csr_mtvec, 1, 5), 32'h1020, 32'h8000_0001, 1, 32'h8000_0103,
            0, 0, 0);
    add_vec(1, csr_instr(2, csr_mtvec, 0, 5), 32'h1024, 0, 1, 32'h102, 0, 0, 0);
    add_vec(1, csr_instr(1, csr_mepc, 1, 0), 32'h1028, 32'h2000_0000, 0, 0, 0, 0, 0);
    add_vec(1, csr_instr(2, csr_mepc, 0, 5), 32'h102c, 0, 1, 32'h2000_0000, 0, 0, 0);
    add_vec(1, csr_instr(5, csr_mstatus, 5'h08, 5), 32'h1030, 0, 1, 0, 0, 0, 0);
    add_vec(1, csr_instr(6, csr_mstatus, 5'h11, 5), 32'h1034, 0, 1, 32'h08, 0, 0, 0);
    add_vec(1, csr_instr(7, csr_mstatus, 5'h10, 5), 32'h1038, 0, 1, 32'h19, 0, 0, 0);
    add_vec(1, csr_instr(7, csr_mstatus, 0, 5), 32'h103c, 0, 1, 32'h09, 0, 0, 0);
    add_vec(1, csr_instr(2, csr_mstatus, 0, 5), 32'h1040, 32'hffff_ffff, 1, 32'h09, 0, 0, 0);
    add_vec(1, csr_instr(7, csr_mvendorid, 0, 5), 32'h1044, 0, 1, mvendorid_val, 0, 0, 0);
    add_vec(1, 32'h0000_0073, 32'h1048, 0, 0, 0, 1, 32'h102, 0); // ecall.
    add_vec(1, csr_instr(2, csr_mepc, 0, 5), 32'h104c, 0, 1, 32'h1048, 0, 0, 0);
    add_vec(1, csr_instr(2, csr_mcause, 0, 5), 32'h1050, 0, 1, 32'd11, 0, 0, 0);
    add_vec(1, csr_instr(2, csr_mstatus, 0, 5), 32'h1054, 0, 1, 32'h81, 0, 0, 0);
    add_vec(1, 32'h3020_0073, 32'h1058, 0, 0, 0, 1, 32'h1048, 0); // mret.
    add_vec(1, csr_instr(2, csr_mstatus, 0, 5), 32'h105c, 0, 1, 32'h89, 0, 0, 0);
    // drop mpie with mie still set, so a second mret must move both bits.
    add_vec(1, csr_instr(3, csr_mstatus, 1, 5), 32'h1060, 32'h80, 1, 32'h89, 0, 0, 0);
    add_vec(1, 32'h3020_0073, 32'h1064, 0, 0, 0, 1, 32'h1048, 0);
    add_vec(1, csr_instr(2, csr_mstatus, 0, 5), 32'h1068, 0, 1, 32'h81, 0, 0, 0);
    add_vec(1, csr_instr(1, 12'h7c0, 1, 5), 32'h106c, 32'h55, 0, 0, 0, 0, 1);
    add_vec(1, csr_instr(1, csr_marchid, 1, 5), 32'h1070, 32'h55, 0, 0, 0, 0, 1);
    add_vec(1, csr_instr(4, csr_mtvec, 1, 5), 32'h1074, 32'hffff_ffff, 0, 0, 0, 0, 1);
    add_vec(0, csr_instr(1, csr_mtvec, 1, 5), 32'h1078, 32'hdead, 0, 0, 0, 0, 0);
    add_vec(0, 32'h0000_0073, 32'h107c, 0, 0, 0, 0, 0, 0);
    add_vec(1, csr_instr(2, csr_mtvec, 0, 5), 32'h1080, 0, 1, 32'h102, 0, 0, 0);
    add_vec(1, csr_instr(2, csr_mepc, 0, 5), 32'h1084, 0, 1, 32'h1048, 0, 0, 0);
    add_vec(1, csr_instr(2, csr_mstatus, 0, 5), 32'h1088, 0, 1, 32'h81, 0, 0, 0);

    wait_cnt = 0;
    while (rst && wait_cnt < 64) begin
      @(posedge clk);
      wait_cnt = wait_cnt + 1;
    end
    if (rst) begin
      errors = errors + 1;
      $display("reset was not released within 64 cycles");
    end else begin
      apply_table();
      run_random();
    end

    @(negedge clk);
    valid = 1'b0;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
source/sys_pkg.sv
source/sys_decode.sv
source/csr_update.sv
source/csr_file.sv
source/sys_commit.sv
source/exu_sys.sv
tests/exu_sys_tb.sv

//--- Bender.yml
package:
  name: exu_sys

sources:
  - files:
      - source/sys_pkg.sv
      - source/sys_decode.sv
      - source/csr_update.sv
      - source/csr_file.sv
      - source/sys_commit.sv
      - source/exu_sys.sv
  - target: test
    files:
      - tests/exu_sys_tb.sv
